// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= lsu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(BUILD_DIR)

// File: lsu.f
rtl/isa_pkg.sv
rtl/bus_pkg.sv
rtl/agu.sv
rtl/store_align.sv
rtl/load_align.sv
rtl/lsu_issue.sv
rtl/lsu.sv
verification/lsu_tb.sv

// File: rtl/agu.sv
// address unit: forms the effective address, flags misalignment and holds the memory-stage op.
`timescale 1ns/1ns
`default_nettype none

module agu
    import isa_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  lsu_req_t   req,
    input  logic       done,
    input  logic       busy,
    output lsu_stage_t stage
);

    word_t      addr_sum;
    logic       misalign;
    lsu_stage_t stage_next;

    // wraps past 32 bits.
    assign addr_sum = req.src1 + req.src2;

    always_comb begin
        case (req.op)
            LH, LHU, SH: begin
                misalign = addr_sum[0];
            end
            LW, SW: begin
                misalign = |addr_sum[1:0];
            end
            default: begin
                misalign = 1'b0;
            end
        endcase
    end

    assign stage_next = '{
        valid:    1'b1,
        op:       req.op,
        addr:     addr_sum,
        wd:       req.wd,
        misalign: misalign
    };

    // only valid is cleared; the rest is payload.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage.valid <= 1'b0;
        end else if (req.valid && !busy) begin
            stage <= stage_next;
        end else if (done) begin
            stage.valid <= 1'b0;
        end
    end

    // requester must wait for busy to drop.
    a_no_strobe_while_busy: assert property (
        @(posedge clk) disable iff (!resetn) busy |-> !req.valid
    );

endmodule

`default_nettype wire

// File: rtl/bus_pkg.sv
// data-bus types and issue states; imported by modules that drive or read the data bus.
`default_nettype none

package bus_pkg;

    import isa_pkg::*;

    localparam int BYTE_LANES = 4;

    typedef logic [BYTE_LANES-1:0] strb_t;

    // valid is a level, held until the response strobe.
    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        strb_t strb;
        word_t wdata;
    } dbus_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } dbus_resp_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_WAIT = 2'd1,
        ST_DONE = 2'd2
    } lsu_state_t;

endpackage

`default_nettype wire

// File: rtl/isa_pkg.sv
// instruction-side types for the load/store unit; imported by every module that sees requests.
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;

    // memory opcodes handled by the memory stage.
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        LB      = 4'd1,
        LBU     = 4'd2,
        LH      = 4'd3,
        LHU     = 4'd4,
        LW      = 4'd5,
        SB      = 4'd6,
        SH      = 4'd7,
        SW      = 4'd8
    } mem_op_t;

    // opcode class masks, one bit per opcode value.
    localparam logic [15:0] is_load_op  = 16'b0000_0000_0011_1110;
    localparam logic [15:0] is_store_op = 16'b0000_0001_1100_0000;

    typedef struct packed {
        logic    valid;
        mem_op_t op;
        word_t   src1;
        word_t   src2;
        word_t   wd;
    } lsu_req_t;

    typedef struct packed {
        logic    valid;
        mem_op_t op;
        word_t   addr;
        word_t   wd;
        logic    misalign;
    } lsu_stage_t;

    typedef struct packed {
        logic  valid;
        word_t data;
        logic  misalign;
        word_t addr;
    } lsu_wb_t;

endpackage

`default_nettype wire

// File: rtl/load_align.sv
// load aligner: picks the addressed byte or halfword from the response and extends it.
`timescale 1ns/1ns
`default_nettype none

module load_align
    import isa_pkg::*;
(
    input  lsu_stage_t stage,
    input  word_t      rdata,
    output word_t      data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    always_comb begin
        case (stage.addr[1:0])
            2'b00: begin
                byte_sel = rdata[7:0];
            end
            2'b01: begin
                byte_sel = rdata[15:8];
            end
            2'b10: begin
                byte_sel = rdata[23:16];
            end
            default: begin
                byte_sel = rdata[31:24];
            end
        endcase
    end

    // addr[0] is zero for any halfword that reaches the bus.
    assign half_sel = stage.addr[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (stage.op)
            LB: begin
                data = {{24{byte_sel[7]}}, byte_sel};
            end
            LBU: begin
                data = {24'b0, byte_sel};
            end
            LH: begin
                data = {{16{half_sel[15]}}, half_sel};
            end
            LHU: begin
                data = {16'b0, half_sel};
            end
            default: begin
                data = rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/lsu.sv
// load/store unit top: connects the address unit, both aligners and the issue controller.
`timescale 1ns/1ns
`default_nettype none

module lsu
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  lsu_req_t   req,
    output logic       busy,
    output dbus_req_t  dbus_req,
    input  dbus_resp_t dbus_resp,
    output lsu_wb_t    wb
);

    lsu_stage_t stage;
    word_t      wdata;
    strb_t      strb;
    word_t      load_data;
    logic       done;

    agu i_agu (
        .clk    (clk),
        .resetn (resetn),
        .req    (req),
        .done   (done),
        .busy   (busy),
        .stage  (stage)
    );

    store_align i_store_align (
        .stage (stage),
        .wdata (wdata),
        .strb  (strb)
    );

    load_align i_load_align (
        .stage (stage),
        .rdata (dbus_resp.rdata),
        .data  (load_data)
    );

    lsu_issue i_lsu_issue (
        .clk       (clk),
        .resetn    (resetn),
        .stage     (stage),
        .wdata     (wdata),
        .strb      (strb),
        .load_data (load_data),
        .dbus_resp (dbus_resp),
        .dbus_req  (dbus_req),
        .wb        (wb),
        .done      (done),
        .busy      (busy)
    );

endmodule

`default_nettype wire

// File: rtl/lsu_issue.sv
// issue controller: FSM that turns the stage and aligner outputs into bus requests and writeback.
`timescale 1ns/1ns
`default_nettype none

module lsu_issue
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  lsu_stage_t stage,
    input  word_t      wdata,
    input  strb_t      strb,
    input  word_t      load_data,
    input  dbus_resp_t dbus_resp,
    output dbus_req_t  dbus_req,
    output lsu_wb_t    wb,
    output logic       done,
    output logic       busy
);

    lsu_state_t state;
    lsu_state_t state_next;
    word_t      wb_data;
    logic       issue;

    // aligned op just entered the stage.
    assign issue = (state == ST_IDLE) && stage.valid && !stage.misalign;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (stage.valid) begin
                    state_next = stage.misalign ? ST_DONE : ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (dbus_resp.valid) begin
                    state_next = ST_DONE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // stores and misaligned ops write back zero.
    always_ff @(posedge clk) begin
        if (state == ST_WAIT && dbus_resp.valid) begin
            wb_data <= is_load_op[stage.op] ? load_data : '0;
        end else if (state == ST_IDLE && stage.valid && stage.misalign) begin
            wb_data <= '0;
        end
    end

    always_comb begin
        dbus_req.valid = issue || (state == ST_WAIT);
        dbus_req.write = is_store_op[stage.op];
        dbus_req.addr  = {stage.addr[31:2], 2'b00};
        dbus_req.strb  = strb;
        dbus_req.wdata = wdata;
    end

    always_comb begin
        wb.valid    = (state == ST_DONE);
        wb.data     = wb_data;
        wb.misalign = stage.misalign;
        wb.addr     = stage.addr;
    end

    assign done = (state == ST_DONE);
    assign busy = stage.valid;

    a_resp_only_in_wait: assert property (
        @(posedge clk) disable iff (!resetn) dbus_resp.valid |-> state == ST_WAIT
    );

    a_req_has_stage: assert property (
        @(posedge clk) disable iff (!resetn) dbus_req.valid |-> stage.valid
    );

endmodule

`default_nettype wire

// File: rtl/store_align.sv
// store aligner: moves store data into its byte lanes and builds the matching byte strobes.
`timescale 1ns/1ns
`default_nettype none

module store_align
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  lsu_stage_t stage,
    output word_t      wdata,
    output strb_t      strb
);

    always_comb begin
        wdata = '0;
        strb  = '0;
        case (stage.op)
            SB: begin
                wdata = {24'b0, stage.wd[7:0]} << {stage.addr[1:0], 3'b000};
                strb  = strb_t'(1'b1) << stage.addr[1:0];
            end
            SH: begin
                if (stage.addr[1]) begin
                    wdata = {stage.wd[15:0], 16'b0};
                    strb  = 4'b1100;
                end else begin
                    wdata = {16'b0, stage.wd[15:0]};
                    strb  = 4'b0011;
                end
            end
            SW: begin
                wdata = stage.wd;
                strb  = '1;
            end
            default: begin
                wdata = '0;
                strb  = '0;
            end
        endcase

        // an aligned store always writes at least one lane.
        if (stage.valid && is_store_op[stage.op] && !stage.misalign) begin
            assert (strb != '0)
                else $error("aligned store with empty byte strobe");
        end
    end

endmodule

`default_nettype wire

// File: verification/lsu_tb.sv
// testbench for the load/store unit; applies a table of memory ops against a bus memory model.
`timescale 1ns/1ns
`default_nettype none

module lsu_tb
    import isa_pkg::*;
    import bus_pkg::*;
();

    typedef struct packed {
        mem_op_t op;
        word_t   src1;
        word_t   src2;
        word_t   wd;
        word_t   mem;
        logic    pre;
        word_t   exp_data;
        logic    exp_mis;
        strb_t   exp_strb;
        word_t   exp_wdata;
    } row_t;

    logic       clk;
    logic       resetn;
    lsu_req_t   req;
    logic       busy;
    dbus_req_t  dbus_req;
    dbus_resp_t dbus_resp = '0;
    lsu_wb_t    wb;

    row_t       tbl[$];
    row_t       cur;
    lsu_wb_t    got;
    word_t      sum;
    string      tag;
    word_t      mem[16];
    logic [3:0] idx;
    dbus_req_t  seen_req;
    logic       pending;
    int         wait_cnt;
    int         req_cnt;
    int         wb_cnt;
    int         wb_start;
    int         req_start;
    int         errors;

    lsu i_lsu (
        .clk       (clk),
        .resetn    (resetn),
        .req       (req),
        .busy      (busy),
        .dbus_req  (dbus_req),
        .dbus_resp (dbus_resp),
        .wb        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    function automatic void fill_table();
        // op, src1, src2, wd, mem word, preload, wb data, misalign, strb, wdata.
        tbl.push_back('{LB, 'h40, 'h0, 'h0, 'h80f17fa5, 1'b1, 'hffffffa5, 1'b0, 4'h0, 'h0});
        tbl.push_back('{LB, 'h3f, 'h2, 'h0, 'h0, 1'b0, 'h7f, 1'b0, 4'h0, 'h0});
        tbl.push_back('{LB, 'h42, 'h0, 'h0, 'h0, 1'b0, 'hfffffff1, 1'b0, 4'h0, 'h0});
        tbl.push_back('{LB, 'h20, 'h23, 'h0, 'h0, 1'b0, 'hffffff80, 1'b0, 4'h0, 'h0});
        tbl.push_back('{LBU, 'h40, 'h0, 'h0, 'h0, 1'b0, 'ha5, 1'b0, 4'h0, 'h0});
        tbl.push_back('{LBU, 'h41, 'h0, 'h0, 'h0, 1'b0, 'h7f, 1'b0, 4'h0, 'h0});
        tbl.push_back('{LBU, 'h42, 'h0, 'h0, 'h0, 1'b0, 'hf1, 1'b0, 4'h0, 'h0});
        // sum wraps to 0x47.
        tbl.push_back('{LBU, 'hffffff00, 'h147, 'h0, 'h12345678, 1'b1, 'h12, 1'b0, 4'h0, 'h0});
        tbl.push_back('{LH, 'h40, 'h0, 'h0, 'h80f17fa5, 1'b1, 'h7fa5, 1'b0, 4'h0, 'h0});
        tbl.push_back('{LH, 'h40, 'h2, 'h0, 'h0, 1'b0, 'hffff80f1, 1'b0, 4'h0, 'h0});
        tbl.push_back('{LHU, 'h40, 'h0, 'h0, 'h0, 1'b0, 'h7fa5, 1'b0, 4'h0, 'h0});
        tbl.push_back('{LHU, 'h42, 'h0, 'h0, 'h0, 1'b0, 'h80f1, 1'b0, 4'h0, 'h0});
        tbl.push_back('{LW, 'hfffffff0, 'h54, 'h0, 'h12345678, 1'b1, 'h12345678, 1'b0, 4'h0, 'h0});
        // byte and halfword merges into one word, then read back.
        tbl.push_back('{SB, 'h48, 'h1, 'hdeadbeef, 'h11111111, 1'b1, 'h0, 1'b0, 4'h2, 'hef00});
        tbl.push_back('{SB, 'h4b, 'h0, 'h44, 'h0, 1'b0, 'h0, 1'b0, 4'h8, 'h44000000});
        tbl.push_back('{SH, 'h48, 'h0, 'h12345678, 'h0, 1'b0, 'h0, 1'b0, 4'h3, 'h5678});
        tbl.push_back('{LW, 'h48, 'h0, 'h0, 'h0, 1'b0, 'h44115678, 1'b0, 4'h0, 'h0});
        tbl.push_back('{SH, 'h4c, 'h2, 'hcafe9abc, 'haaaaaaaa, 1'b1, 'h0, 1'b0, 4'hc, 'h9abc0000});
        tbl.push_back('{SB, 'h4c, 'h0, 'h77, 'h0, 1'b0, 'h0, 1'b0, 4'h1, 'h77});
        tbl.push_back('{SB, 'h4e, 'h0, 'h5a, 'h0, 1'b0, 'h0, 1'b0, 4'h4, 'h5a0000});
        tbl.push_back('{LW, 'h4c, 'h0, 'h0, 'h0, 1'b0, 'h9a5aaa77, 1'b0, 4'h0, 'h0});
        tbl.push_back('{SW, 'h50, 'h0, 'hfeedf00d, 'h0, 1'b1, 'h0, 1'b0, 4'hf, 'hfeedf00d});
        tbl.push_back('{LW, 'h50, 'h0, 'h0, 'h0, 1'b0, 'hfeedf00d, 1'b0, 4'h0, 'h0});
        // misaligned ops never reach the bus.
        tbl.push_back('{LH, 'h41, 'h0, 'h0, 'h0, 1'b0, 'h0, 1'b1, 4'h0, 'h0});
        tbl.push_back('{SH, 'h4d, 'h0, 'hffff, 'h0, 1'b0, 'h0, 1'b1, 4'h0, 'h0});
        tbl.push_back('{LW, 'h42, 'h0, 'h0, 'h0, 1'b0, 'h0, 1'b1, 4'h0, 'h0});
        tbl.push_back('{SW, 'h50, 'h3, 'h0bad0bad, 'h0, 1'b0, 'h0, 1'b1, 4'h0, 'h0});
        tbl.push_back('{LW, 'h50, 'h0, 'h0, 'h0, 1'b0, 'hfeedf00d, 1'b0, 4'h0, 'h0});
    endfunction

    // bus memory; a pending request is answered after 0 to 3 cycles.
    always @(posedge clk) begin
        if (!resetn) begin
            dbus_resp <= '0;
            pending = 1'b0;
        end else if (dbus_resp.valid) begin
            dbus_resp.valid <= 1'b0;
            pending = 1'b0;
        end else if (dbus_req.valid) begin
            idx = dbus_req.addr[5:2];
            if (!pending) begin
                pending = 1'b1;
                wait_cnt = $urandom % 4;
                seen_req = dbus_req;
                req_cnt++;
                if (cur.pre) begin
                    mem[idx] = cur.mem;
                end
            end
            if (wait_cnt == 0) begin
                for (int i = 0; i < BYTE_LANES; i++) begin
                    if (dbus_req.write && dbus_req.strb[i]) begin
                        mem[idx][8*i +: 8] = dbus_req.wdata[8*i +: 8];
                    end
                end
                dbus_resp <= '{valid: 1'b1, rdata: mem[idx]};
            end else begin
                wait_cnt--;
            end
        end
    end

    always @(posedge clk) begin
        if (resetn && wb.valid) begin
            wb_cnt++;
        end
    end

    // ends a hung run after ten cycles per row plus reset.
    initial begin
        @(posedge clk);
        repeat (tbl.size() * 10 + 10) @(posedge clk);
        $display("timeout: no result after %0d cycles", tbl.size() * 10 + 10);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h9389));
        req    = '0;
        resetn = 1'b0;
        fill_table();
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        compare("busy after reset", word_t'(busy), '0);
        compare("dbus_req.valid after reset", word_t'(dbus_req.valid), '0);
        compare("wb.valid after reset", word_t'(wb.valid), '0);

        foreach (tbl[i]) begin
            while (busy) begin
                @(posedge clk);
            end
            cur       = tbl[i];
            sum       = cur.src1 + cur.src2;
            tag       = $sformatf("row %0d ", i);
            wb_start  = wb_cnt;
            req_start = req_cnt;
            req <= '{valid: 1'b1, op: cur.op, src1: cur.src1, src2: cur.src2, wd: cur.wd};
            @(posedge clk);
            req.valid <= 1'b0;
            while (!wb.valid) begin
                @(posedge clk);
            end
            got = wb;
            @(posedge clk);
            compare({tag, "wb.data"}, got.data, cur.exp_data);
            compare({tag, "wb.misalign"}, word_t'(got.misalign), word_t'(cur.exp_mis));
            compare({tag, "wb.addr"}, got.addr, sum);
            compare({tag, "wb pulses"}, word_t'(wb_cnt - wb_start), 1);
            if (cur.exp_mis) begin
                compare({tag, "bus requests"}, word_t'(req_cnt - req_start), 0);
            end else begin
                compare({tag, "bus requests"}, word_t'(req_cnt - req_start), 1);
                compare({tag, "dbus_req.addr"}, seen_req.addr, sum & 32'hfffffffc);
                compare({tag, "dbus_req.write"}, word_t'(seen_req.write),
                        word_t'(cur.op inside {SB, SH, SW}));
                compare({tag, "dbus_req.strb"}, word_t'(seen_req.strb), word_t'(cur.exp_strb));
                compare({tag, "dbus_req.wdata"}, seen_req.wdata, cur.exp_wdata);
            end
        end

        $display("finished %0d rows with %0d errors", tbl.size(), errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
